// File: video_pkg.sv
// Shared sizes, register map and pixel fields of the tilemap renderer, referenced by scoped name
package video_pkg;

    // Line and tile geometry
    localparam int num_layers = 3;
    localparam int line_w     = 64;                  // Pixels per output line
    localparam int tile_w     = 8;                   // Tiles are square
    localparam int map_tiles  = 32;                  // Map is 256 pixels each way
    localparam int fine_bits  = $clog2(tile_w);      // Pixel offset within a tile
    localparam int buf_bits   = $clog2(line_w);      // Line buffer address

    // With a fine horizontal offset one line touches one extra tile
    localparam int line_tiles = line_w / tile_w + 1;

    // Map entry: palette in the top bits, tile code below
    localparam int pal_bits  = 4;
    localparam int code_bits = 12;

    // Pixel index per ROM nibble, 0 means transparent
    localparam int pix_bits = 4;

    // Mixed pixel is {layer, palette, index}
    localparam int layer_bits  = 2;
    localparam int colour_bits = layer_bits + pal_bits + pix_bits;

    // Register map as word indexes
    // Layer l owns words reg_group*l up to reg_group*l + 2
    localparam int reg_hpos  = 0;                    // Horizontal scroll
    localparam int reg_vpos  = 1;                    // Vertical scroll
    localparam int reg_base  = 2;                    // Tile map base in VRAM
    localparam int reg_group = 3;                    // Words per layer

    // Control word, bit l enables layer l
    localparam int reg_ctrl  = 9;

    // Words at or above this index answer with an error
    localparam int reg_count = 10;

endpackage

// File: video_regs.sv
`timescale 1ns/10ps
// APB slave holding the scroll, map base and enable registers that configure each tile layer
module video_regs (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [7:0]                               paddr,
    input  logic                                     psel,
    input  logic                                     penable,
    input  logic                                     pwrite,
    input  logic [15:0]                              pwdata,
    output logic [15:0]                              prdata,
    output logic                                     pready,
    output logic                                     pslverr,
    output logic [video_pkg::num_layers-1:0][15:0]   hpos,
    output logic [video_pkg::num_layers-1:0][15:0]   vpos,
    output logic [video_pkg::num_layers-1:0][15:0]   vram_base,
    output logic [video_pkg::num_layers-1:0]         enable
);

    logic [15:0] regs [video_pkg::reg_count];
    logic [5:0]  idx;            // Word index, byte address on a 32-bit grid
    logic        bad;
    logic        wr_en;

    assign idx = paddr[7:2];
    assign bad = idx >= 6'(video_pkg::reg_count);

    // Write lands on the edge that closes the access phase
    assign wr_en = psel && penable && pwrite && !bad;

    assign pready  = 1'b1;       // No wait states
    assign pslverr = psel && penable && bad;

    // Reads out of range return zero
    assign prdata = (psel && !bad) ? regs[idx[3:0]] : 16'h0000;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < video_pkg::reg_count; i++) begin
                regs[i] <= 16'h0000;
            end
        end else if (wr_en) begin
            regs[idx[3:0]] <= pwdata;
        end
    end

    // Spread the register file over the layer ports
    always_comb begin
        for (int l = 0; l < video_pkg::num_layers; l++) begin
            hpos[l]      = regs[video_pkg::reg_group * l + video_pkg::reg_hpos];
            vpos[l]      = regs[video_pkg::reg_group * l + video_pkg::reg_vpos];
            vram_base[l] = regs[video_pkg::reg_group * l + video_pkg::reg_base];
        end
        enable = regs[video_pkg::reg_ctrl][video_pkg::num_layers-1:0];
    end

endmodule

// File: tilemap_layer.sv
`timescale 1ns/10ps
// One scroll layer, fetches map entries and tile rows for line v and fills its mixer buffer
module tilemap_layer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start,
    input  logic [7:0]                            v,
    input  logic [video_pkg::layer_bits-1:0]      layer,
    input  logic [15:0]                           hpos,
    input  logic [15:0]                           vpos,
    input  logic [15:0]                           vram_base,
    input  logic                                  enable,
    output logic                                  vram_cs,
    output logic [15:0]                           vram_addr,
    input  logic [15:0]                           vram_data,
    input  logic                                  vram_ok,
    output logic                                  rom_cs,
    output logic [15:0]                           rom_addr,
    input  logic [31:0]                           rom_data,
    input  logic                                  rom_ok,
    output logic [video_pkg::buf_bits-1:0]        buf_addr,
    output logic [video_pkg::colour_bits-1:0]     buf_data,
    output logic                                  buf_wr,
    output logic                                  done
);

    logic                                busy;      // Line in progress
    logic                                off;       // Layer disabled for this line
    logic [7:0]                          row_y;     // Map row in pixels, wraps at 256
    logic [7:0]                          scr_x;
    logic [15:0]                         base;
    logic [6:0]                          clr_cnt;
    logic [3:0]                          f_tile;    // Tile in the fetch stage
    logic                                f_ready;   // Fetched row waits for the write stage
    logic [video_pkg::code_bits-1:0]     f_code;
    logic [video_pkg::pal_bits-1:0]      f_pal;
    logic [31:0]                         f_row;
    logic                                p_valid;
    logic [3:0]                          p_tile;
    logic [video_pkg::fine_bits-1:0]     p_pix;
    logic [video_pkg::pal_bits-1:0]      p_pal;
    logic [31:0]                         p_row;
    logic [4:0]                          map_col;
    logic [video_pkg::pix_bits-1:0]      nib;
    logic [6:0]                          scr_pos;
    logic                                p_last;
    logic                                load;

    assign map_col   = scr_x[7:video_pkg::fine_bits] + 5'(f_tile);   // Wraps at 32 tiles
    assign vram_addr = base + 16'(row_y[7:video_pkg::fine_bits]) * 16'(video_pkg::map_tiles)
                     + 16'(map_col);
    assign rom_addr  = 16'(f_code) * 16'(video_pkg::tile_w)
                     + 16'(row_y[video_pkg::fine_bits-1:0]);

    assign nib = p_row[p_pix * video_pkg::pix_bits +: video_pkg::pix_bits];

    // Screen x of the current pixel, bit 6 set means off screen on either side
    assign scr_pos = {p_tile, p_pix} - 7'(scr_x[video_pkg::fine_bits-1:0]);

    assign p_last = p_valid && (p_pix == 3'(video_pkg::tile_w - 1));
    assign load   = f_ready && (!p_valid || p_last);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            off     <= 1'b0;
            vram_cs <= 1'b0;
            rom_cs  <= 1'b0;
            f_tile  <= 4'd0;
            f_ready <= 1'b0;
            p_valid <= 1'b0;
            buf_wr  <= 1'b0;
            done    <= 1'b0;
        end else begin
            buf_wr <= 1'b0;
            done   <= 1'b0;
            if (start && !busy) begin
                busy    <= 1'b1;
                off     <= !enable;
                vram_cs <= enable;          // First map read right away
                f_tile  <= 4'd0;
                f_ready <= 1'b0;
                p_valid <= 1'b0;
            end else if (busy && off) begin
                if (clr_cnt[6]) begin
                    done <= 1'b1;
                    busy <= 1'b0;
                end else begin
                    buf_wr <= 1'b1;
                end
            end else if (busy) begin
                if (vram_cs && vram_ok) begin
                    vram_cs <= 1'b0;
                    rom_cs  <= 1'b1;
                end
                if (rom_cs && rom_ok) begin
                    rom_cs  <= 1'b0;
                    f_ready <= 1'b1;
                end
                // Hand the row over and start on the next map entry
                if (load) begin
                    f_ready <= 1'b0;
                    p_valid <= 1'b1;
                    if (f_tile != 4'(video_pkg::line_tiles - 1)) begin
                        f_tile  <= f_tile + 4'd1;
                        vram_cs <= 1'b1;
                    end
                end else if (p_last) begin
                    p_valid <= 1'b0;
                end
                if (p_valid) begin
                    buf_wr <= !scr_pos[6];
                end
                if (p_last && p_tile == 4'(video_pkg::line_tiles - 1)) begin
                    done <= 1'b1;
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            row_y   <= v + vpos[7:0];
            scr_x   <= hpos[7:0];
            base    <= vram_base;
            clr_cnt <= 7'd0;
        end
        if (busy && off) begin              // Clear pass, one zero per cycle
            clr_cnt  <= clr_cnt + 7'd1;
            buf_addr <= clr_cnt[video_pkg::buf_bits-1:0];
            buf_data <= '0;
        end
        if (vram_cs && vram_ok) begin
            f_code <= vram_data[video_pkg::code_bits-1:0];
            f_pal  <= vram_data[15 -: video_pkg::pal_bits];
        end
        if (rom_cs && rom_ok) begin
            f_row <= rom_data;
        end
        if (p_valid) begin
            p_pix    <= p_pix + 1'b1;
            buf_addr <= scr_pos[video_pkg::buf_bits-1:0];
            buf_data <= (nib == '0) ? '0 : {layer, p_pal, nib};
        end
        if (load) begin
            p_row  <= f_row;
            p_pal  <= f_pal;
            p_tile <= f_tile;
            p_pix  <= '0;
        end
    end

endmodule

// File: line_mixer.sv
`timescale 1ns/10ps
// Per-layer line buffers, fixed priority merge and the pixel stream into the frame buffer
module line_mixer (
    input  logic                                                     clk,
    input  logic                                                     rst_n,
    input  logic [video_pkg::num_layers-1:0][video_pkg::buf_bits-1:0]    buf_addr,
    input  logic [video_pkg::num_layers-1:0][video_pkg::colour_bits-1:0] buf_data,
    input  logic [video_pkg::num_layers-1:0]                         buf_wr,
    input  logic [video_pkg::num_layers-1:0]                         done,
    output logic [video_pkg::buf_bits-1:0]                           line_addr,
    output logic [video_pkg::colour_bits-1:0]                        line_data,
    output logic                                                     line_wr,
    input  logic                                                     line_wr_ok,
    output logic                                                     line_done
);

    logic [video_pkg::colour_bits-1:0] mem [video_pkg::num_layers][video_pkg::line_w];
    logic [video_pkg::num_layers-1:0]  got;       // Layers finished with this line
    logic                              all_in;
    logic                              take;

    assign all_in = &(got | done);
    assign take   = line_wr && line_wr_ok;       // Frame buffer accepted the pixel

    always_ff @(posedge clk) begin
        for (int l = 0; l < video_pkg::num_layers; l++) begin
            if (buf_wr[l]) begin
                mem[l][buf_addr[l]] <= buf_data[l];
            end
        end
    end

    // Layer 0 on top, a zero index lets the layer below show through
    always_comb begin
        line_data = '0;
        for (int l = video_pkg::num_layers - 1; l >= 0; l--) begin
            if (mem[l][line_addr][video_pkg::pix_bits-1:0] != '0) begin
                line_data = mem[l][line_addr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            got       <= '0;
            line_wr   <= 1'b0;
            line_addr <= '0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            got       <= got | done;
            if (!line_wr && all_in) begin
                line_wr   <= 1'b1;              // Pixel 0 goes out next cycle
                line_addr <= '0;
            end else if (take) begin
                if (line_addr == video_pkg::buf_bits'(video_pkg::line_w - 1)) begin
                    line_wr   <= 1'b0;
                    line_done <= 1'b1;
                    got       <= '0;            // Ready for the next line
                end else begin
                    line_addr <= line_addr + 1'b1;
                end
            end
        end
    end

endmodule

// File: video_top.sv
`timescale 1ns/10ps
// Renderer top level joining the APB registers, the scroll layer array and the line mixer
module video_top (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             start,
    input  logic [7:0]                                       v,
    // APB host
    input  logic [7:0]                                       paddr,
    input  logic                                             psel,
    input  logic                                             penable,
    input  logic                                             pwrite,
    input  logic [15:0]                                      pwdata,
    output logic [15:0]                                      prdata,
    output logic                                             pready,
    output logic                                             pslverr,
    // Tile map VRAM, one port per layer
    output logic [video_pkg::num_layers-1:0]                 vram_cs,
    output logic [video_pkg::num_layers-1:0][15:0]           vram_addr,
    input  logic [video_pkg::num_layers-1:0][15:0]           vram_data,
    input  logic [video_pkg::num_layers-1:0]                 vram_ok,
    // Graphics ROM
    output logic [video_pkg::num_layers-1:0]                 rom_cs,
    output logic [video_pkg::num_layers-1:0][15:0]           rom_addr,
    input  logic [video_pkg::num_layers-1:0][31:0]           rom_data,
    input  logic [video_pkg::num_layers-1:0]                 rom_ok,
    // Frame buffer
    output logic [video_pkg::buf_bits-1:0]                   line_addr,
    output logic [video_pkg::colour_bits-1:0]                line_data,
    output logic                                             line_wr,
    input  logic                                             line_wr_ok,
    output logic                                             line_done
);

    logic [video_pkg::num_layers-1:0][15:0]                  hpos;
    logic [video_pkg::num_layers-1:0][15:0]                  vpos;
    logic [video_pkg::num_layers-1:0][15:0]                  vram_base;
    logic [video_pkg::num_layers-1:0]                        enable;
    logic [video_pkg::num_layers-1:0][video_pkg::buf_bits-1:0]    buf_addr;
    logic [video_pkg::num_layers-1:0][video_pkg::colour_bits-1:0] buf_data;
    logic [video_pkg::num_layers-1:0]                        buf_wr;
    logic [video_pkg::num_layers-1:0]                        done;

    video_regs u_regs (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .paddr     ( paddr     ),
        .psel      ( psel      ),
        .penable   ( penable   ),
        .pwrite    ( pwrite    ),
        .pwdata    ( pwdata    ),
        .prdata    ( prdata    ),
        .pready    ( pready    ),
        .pslverr   ( pslverr   ),
        .hpos      ( hpos      ),
        .vpos      ( vpos      ),
        .vram_base ( vram_base ),
        .enable    ( enable    )
    );

    // Identical 8x8 layers, the index only tags the mixed pixel
    genvar i;
    generate
        for (i = 0; i < video_pkg::num_layers; i++) begin : g_layer
            tilemap_layer u_layer (
                .clk       ( clk          ),
                .rst_n     ( rst_n        ),
                .start     ( start        ),
                .v         ( v            ),
                .layer     ( 2'(i)        ),
                .hpos      ( hpos[i]      ),
                .vpos      ( vpos[i]      ),
                .vram_base ( vram_base[i] ),
                .enable    ( enable[i]    ),
                .vram_cs   ( vram_cs[i]   ),
                .vram_addr ( vram_addr[i] ),
                .vram_data ( vram_data[i] ),
                .vram_ok   ( vram_ok[i]   ),
                .rom_cs    ( rom_cs[i]    ),
                .rom_addr  ( rom_addr[i]  ),
                .rom_data  ( rom_data[i]  ),
                .rom_ok    ( rom_ok[i]    ),
                .buf_addr  ( buf_addr[i]  ),
                .buf_data  ( buf_data[i]  ),
                .buf_wr    ( buf_wr[i]    ),
                .done      ( done[i]      )
            );
        end
    endgenerate

    line_mixer u_mix (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .buf_addr   ( buf_addr   ),
        .buf_data   ( buf_data   ),
        .buf_wr     ( buf_wr     ),
        .done       ( done       ),
        .line_addr  ( line_addr  ),
        .line_data  ( line_data  ),
        .line_wr    ( line_wr    ),
        .line_wr_ok ( line_wr_ok ),
        .line_done  ( line_done  )
    );

endmodule

// File: tb_clock.sv
`timescale 1ns/10ps
// Free-running clock for the renderer testbench, 8 ns period, instantiated once by video_tb
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;      // Half period
        end
    end

endmodule

// File: video_tb.sv
`timescale 1ns/10ps
// Testbench for video_top that models VRAM and ROM per layer, programs APB and checks every line
module video_tb;

    localparam int nl = video_pkg::num_layers;
    // Budget of 6 lines x 64 px x 3 layers x 12 cycles plus APB traffic rounded up
    localparam int max_cycles = 20_000;

    logic                clk;
    logic                rst_n;
    logic                start;
    logic [7:0]          v;
    logic [7:0]          paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [15:0]         pwdata;
    logic [15:0]         prdata;
    logic                pready;
    logic                pslverr;
    logic [nl-1:0]       vram_cs;
    logic [nl-1:0][15:0] vram_addr;
    logic [nl-1:0][15:0] vram_data;
    logic [nl-1:0]       vram_ok;
    logic [nl-1:0]       rom_cs;
    logic [nl-1:0][15:0] rom_addr;
    logic [nl-1:0][31:0] rom_data;
    logic [nl-1:0]       rom_ok;
    logic [5:0]          line_addr;
    logic [9:0]          line_data;
    logic                line_wr;
    logic                line_wr_ok;
    logic                line_done;

    // Copy of the layer setup for the reference model
    logic [15:0]   t_hpos [nl];
    logic [15:0]   t_vpos [nl];
    logic [15:0]   t_base [nl];
    logic [nl-1:0] t_en;
    logic [7:0]    t_v;

    logic [31:0] rng;
    logic [2:0]  vwait [nl];    // Cycles left until ok or 0 when idle
    logic [2:0]  rwait [nl];
    logic [9:0]  exp_px;
    logic        want_done;
    logic        in_line;
    int          exp_addr;
    int          accepted;
    int          cycles;
    int          errors;
    int          err_mark;
    int          tests;
    int          failed;
    string       test_name;

    tb_clock u_clk (.clk(clk));

    video_top uut (
        .clk(clk), .rst_n(rst_n), .start(start), .v(v),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .vram_cs(vram_cs), .vram_addr(vram_addr), .vram_data(vram_data), .vram_ok(vram_ok),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok),
        .line_addr(line_addr), .line_data(line_data), .line_wr(line_wr),
        .line_wr_ok(line_wr_ok), .line_done(line_done)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Map entry {pal, code} seen by layer l at address a
    function automatic logic [15:0] vram_word(input int l, input logic [15:0] a);
        logic [11:0] code;
        logic [3:0]  pal;
        code = 12'(32'(a) * 32'd7 + 32'(l));
        pal  = 4'(32'(a) + 32'(l));
        return {pal, code};
    endfunction

    function automatic logic [31:0] rom_word(input int l, input logic [15:0] a);
        logic [31:0] w;
        w = xorshift(32'(a) * 32'd3 + 32'(l) + 32'h2db7);
        if (a[0]) begin
            w[3:0] = 4'h0;      // Transparent pixel 0 on odd rows
        end
        return w;
    endfunction

    function automatic logic [9:0] layer_pixel(input int l, input int x);
        logic [7:0]  yy;
        logic [7:0]  xx;
        logic [15:0] vaddr;
        logic [15:0] entry;
        logic [15:0] raddr;
        logic [31:0] row;
        logic [3:0]  pix;
        if (!t_en[l]) begin
            return '0;
        end
        yy    = t_v + t_vpos[l][7:0];               // Both wrap at 256 pixels
        xx    = 8'(x) + t_hpos[l][7:0];
        vaddr = t_base[l] + 16'(yy[7:3]) * 16'(video_pkg::map_tiles) + 16'(xx[7:3]);
        entry = vram_word(l, vaddr);
        raddr = 16'(entry[11:0]) * 16'(video_pkg::tile_w) + 16'(yy[2:0]);
        row   = rom_word(l, raddr);
        pix   = row[int'(xx[2:0]) * video_pkg::pix_bits +: video_pkg::pix_bits];
        if (pix == 4'h0) begin
            return '0;
        end
        return {2'(l), entry[15:12], pix};
    endfunction

    // Lowest layer number with a visible pixel wins
    function automatic logic [9:0] expected_pixel(input int x);
        logic [9:0] p;
        for (int l = 0; l < nl; l++) begin
            p = layer_pixel(l, x);
            if (p[3:0] != 4'h0) begin
                return p;
            end
        end
        return '0;
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: no finish after %0d cycles, a line never completed", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // VRAM and ROM answer 1 to 4 cycles after cs while the frame buffer stalls now and then
    always @(posedge clk) begin
        rng = xorshift(rng);
        line_wr_ok <= (rng[3:2] != 2'b00);
        for (int l = 0; l < nl; l++) begin
            vram_ok[l] <= 1'b0;
            rom_ok[l]  <= 1'b0;
            if (!rst_n) begin
                vwait[l] <= 3'd0;
                rwait[l] <= 3'd0;
            end else begin
                if (vram_cs[l] && !vram_ok[l]) begin
                    if (vwait[l] == 3'd0) begin
                        rng = xorshift(rng);
                        if (rng[1:0] == 2'd0) begin
                            vram_ok[l]   <= 1'b1;
                            vram_data[l] <= vram_word(l, vram_addr[l]);
                        end else begin
                            vwait[l] <= 3'(rng[1:0]);
                        end
                    end else if (vwait[l] == 3'd1) begin
                        vram_ok[l]   <= 1'b1;
                        vram_data[l] <= vram_word(l, vram_addr[l]);
                        vwait[l]     <= 3'd0;
                    end else begin
                        vwait[l] <= vwait[l] - 3'd1;
                    end
                end
                if (rom_cs[l] && !rom_ok[l]) begin
                    if (rwait[l] == 3'd0) begin
                        rng = xorshift(rng);
                        if (rng[1:0] == 2'd0) begin
                            rom_ok[l]   <= 1'b1;
                            rom_data[l] <= rom_word(l, rom_addr[l]);
                        end else begin
                            rwait[l] <= 3'(rng[1:0]);
                        end
                    end else if (rwait[l] == 3'd1) begin
                        rom_ok[l]   <= 1'b1;
                        rom_data[l] <= rom_word(l, rom_addr[l]);
                        rwait[l]    <= 3'd0;
                    end else begin
                        rwait[l] <= rwait[l] - 3'd1;
                    end
                end
            end
        end
    end

    // Output stream checks on the edges where the DUT samples the same values
    always @(posedge clk) begin
        if (!rst_n) begin
            want_done = 1'b0;
            in_line   = 1'b0;
            exp_addr  = 0;
            accepted  = 0;
        end else begin
            assert (line_done == want_done) else begin
                $display("ERR %s: line_done expected %0b actual %0b",
                         test_name, want_done, line_done);
                errors++;
            end
            want_done = 1'b0;
            if (line_done) begin
                in_line = 1'b0;
            end
            if (start) begin
                in_line  = 1'b1;
                exp_addr = 0;
                accepted = 0;
            end
            assert (in_line || !line_wr) else begin
                $display("%s: line_wr is high after line_done with no new start", test_name);
                errors++;
            end
            if (in_line && t_en == '0) begin
                assert (vram_cs == '0 && rom_cs == '0) else begin
                    $display("%s: a memory cs went high with every layer disabled", test_name);
                    errors++;
                end
            end
            if (line_wr && line_wr_ok) begin
                assert (exp_addr < video_pkg::line_w) else begin
                    $display("%s: more than %0d pixels accepted in one line",
                             test_name, video_pkg::line_w);
                    errors++;
                end
                exp_px = expected_pixel(exp_addr);
                assert (line_addr == 6'(exp_addr)) else begin
                    $display("ERR %s: write address expected %0d actual %0d",
                             test_name, exp_addr, line_addr);
                    errors++;
                end
                assert (line_data == exp_px) else begin
                    $display("ERR %s: pixel %0d expected %03h actual %03h",
                             test_name, exp_addr, exp_px, line_data);
                    errors++;
                end
                want_done = (exp_addr == video_pkg::line_w - 1);
                exp_addr++;
                accepted++;
            end
        end
    end

    task automatic apb_access(input logic [5:0] idx, input logic wr, input logic [15:0] wdata,
                              output logic [15:0] rdata, output logic err);
        @(posedge clk);
        paddr   <= {idx, 2'b00};
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        rdata   = prdata;           // Access phase closes on this edge
        err     = pslverr;
        assert (pready) else begin
            $display("%s: pready was low in the access phase", test_name);
            errors++;
        end
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input int idx, input logic [15:0] data);
        logic [15:0] rd;
        logic        err;
        apb_access(6'(idx), 1'b1, data, rd, err);
        assert (!err) else begin
            $display("%s: pslverr on a write to register %0d", test_name, idx);
            errors++;
        end
    endtask

    task automatic setup_layer(input int l, input logic [15:0] h, input logic [15:0] vs,
                               input logic [15:0] base);
        apb_write(video_pkg::reg_group * l + video_pkg::reg_hpos, h);
        apb_write(video_pkg::reg_group * l + video_pkg::reg_vpos, vs);
        apb_write(video_pkg::reg_group * l + video_pkg::reg_base, base);
        t_hpos[l] = h;
        t_vpos[l] = vs;
        t_base[l] = base;
    endtask

    task automatic set_enables(input logic [nl-1:0] mask);
        apb_write(video_pkg::reg_ctrl, 16'(mask));
        t_en = mask;
    endtask

    task automatic render_line(input logic [7:0] line);
        t_v = line;
        @(posedge clk);
        v     <= line;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        while (!line_done) begin
            @(posedge clk);
        end
        @(posedge clk);             // Checker has handled the line_done edge
        assert (accepted == video_pkg::line_w) else begin
            $display("ERR %s: accepted writes expected %0d actual %0d",
                     test_name, video_pkg::line_w, accepted);
            errors++;
        end
    endtask

    task automatic open_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic close_test();
        tests++;
        if (errors == err_mark) begin
            $display("test %s: pass", test_name);
        end else begin
            failed++;
            $display("test %s: FAIL with %0d errors", test_name, errors - err_mark);
        end
    endtask

    task automatic check_registers();
        logic [15:0] rd;
        logic        err;
        for (int i = 0; i < video_pkg::reg_count; i++) begin
            apb_write(i, 16'(i * 16'h1357 + 16'h00a5));
        end
        for (int i = 0; i < video_pkg::reg_count; i++) begin
            apb_access(6'(i), 1'b0, 16'h0000, rd, err);
            assert (rd == 16'(i * 16'h1357 + 16'h00a5) && !err) else begin
                $display("ERR %s: register %0d expected %04h actual %04h",
                         test_name, i, 16'(i * 16'h1357 + 16'h00a5), rd);
                errors++;
            end
        end
        apb_access(6'd12, 1'b1, 16'hbeef, rd, err);
        assert (err) else begin
            $display("%s: pslverr stayed low on a write to index 12", test_name);
            errors++;
        end
        apb_access(6'd12, 1'b0, 16'h0000, rd, err);
        assert (err && rd == 16'h0000) else begin
            $display("ERR %s: index 12 read expected 0000 with pslverr, actual %04h err %0b",
                     test_name, rd, err);
            errors++;
        end
    endtask

    initial begin
        rng        = 32'h2db7;
        cycles     = 0;
        errors     = 0;
        tests      = 0;
        failed     = 0;
        test_name  = "reset";
        rst_n      = 1'b0;
        start      = 1'b0;
        v          = 8'd0;
        paddr      = 8'd0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = 16'h0000;
        vram_ok    = '0;
        vram_data  = '0;
        rom_ok     = '0;
        rom_data   = '0;
        line_wr_ok = 1'b0;
        t_en       = '0;
        t_v        = 8'd0;
        for (int l = 0; l < nl; l++) begin
            t_hpos[l] = 16'h0000;
            t_vpos[l] = 16'h0000;
            t_base[l] = 16'h0000;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        open_test("apb_regs");
        check_registers();
        close_test();

        open_test("single_layer");
        setup_layer(2, 16'd0, 16'd0, 16'h0400);
        set_enables(3'b100);
        render_line(8'd5);
        close_test();

        open_test("scroll");
        setup_layer(1, 16'd250, 16'd3, 16'h0800);
        set_enables(3'b010);
        render_line(8'd254);
        close_test();

        open_test("priority");
        setup_layer(0, 16'd13, 16'd7, 16'h0000);
        setup_layer(1, 16'd90, 16'd200, 16'h0800);
        setup_layer(2, 16'd5, 16'd60, 16'h0400);
        set_enables(3'b111);
        render_line(8'd100);
        close_test();

        open_test("back_pressure");
        setup_layer(0, 16'd201, 16'd33, 16'h0c00);
        render_line(8'd37);
        close_test();

        open_test("disabled");
        set_enables(3'b000);
        render_line(8'd9);
        close_test();

        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 tests, tests - failed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: video_top.f
video_pkg.sv
video_regs.sv
tilemap_layer.sv
line_mixer.sv
video_top.sv
tb_clock.sv
video_tb.sv

// File: Makefile
TOP = video_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f video_top.f --top-module video_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f video_top.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
